// ==== verilog/fetch_types_pkg.sv ====
// Width constants and vector typedefs for addresses, words and parcels, plus the full-opcode marker
`default_nettype none

package fetch_types_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int unsigned XLEN   = 32;        // Address and word width of the core
  localparam int unsigned HALF_W = XLEN / 2;  // One instruction parcel

  //////////////////////////////
  // Vector types
  //////////////////////////////

  typedef logic [XLEN-1:0]   addr_t;  // Byte address
  typedef logic [XLEN-1:0]   word_t;  // Memory word or assembled instruction
  typedef logic [HALF_W-1:0] half_t;  // 16-bit instruction parcel

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // A parcel whose two low bits equal this value starts a 32-bit instruction
  // Every other value marks a compressed instruction
  localparam logic [1:0] FULL_OPCODE_BITS = 2'b11;

endpackage : fetch_types_pkg

`default_nettype wire

// ==== verilog/fetch_ctrl_pkg.sv ====
// Memory access state enum and instruction format enum shared by control and aligner
`default_nettype none

package fetch_ctrl_pkg;

  // Progress of the single outstanding memory access
  typedef enum logic [1:0] {
    IDLE,          // No access in flight
    WAIT_GNT,      // Request raised and not yet granted
    WAIT_RVALID,   // Granted and the response is still to come
    WAIT_ABORTED   // Granted before a branch so the response gets dropped
  } mem_state_e;

  // Where the instruction at the PC sits in the holding registers
  typedef enum logic [1:0] {
    LINE_LOW_C,    // Compressed parcel in the lower half of the line
    LINE_FULL,     // Word-aligned 32-bit instruction filling the line
    LINE_HIGH_C,   // Compressed parcel in the upper half of the line
    STRADDLE       // Held upper half below the lower half of the next line
  } instr_fmt_e;

endpackage : fetch_ctrl_pkg

`default_nettype wire

// ==== verilog/fetch_addr_unit.sv ====
// Program counter with shared +2/+4 adder, branch load and word-aligned memory address
`default_nettype none

module fetch_addr_unit
  import fetch_types_pkg::*;
#(
  parameter addr_t RESET_PC = '0  // Start address until the first branch
) (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  pc_load_i,        // Take the branch target
  input  wire addr_t branch_addr_i,
  input  wire logic  pc_advance_i,     // Step past the transferred instruction
  input  wire logic  step4_i,          // Full instruction when set, compressed otherwise
  input  wire logic  req_next_word_i,  // Fetch the word after the PC for a straddle
  output addr_t      pc_o,
  output addr_t      mem_addr_o
);

  addr_t pc_q;
  addr_t step;  // Adder operand
  addr_t sum;   // Single adder output shared by the PC step and the next-word address

  // The next word and a 4-byte step use the same operand and never occur together with +2
  assign step = (req_next_word_i || step4_i) ? addr_t'(4) : addr_t'(2);
  assign sum  = pc_q + step;

  // During a straddle the PC keeps the instruction's own address
  // The second word comes from the adder instead of a saved copy
  assign mem_addr_o = req_next_word_i ? {sum[XLEN-1:2], 2'b00} : {pc_q[XLEN-1:2], 2'b00};
  assign pc_o       = pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (pc_load_i) begin
      pc_q <= branch_addr_i;  // Branch wins over any step
    end else if (pc_advance_i) begin
      pc_q <= sum;
    end
  end

endmodule : fetch_addr_unit

`default_nettype wire

// ==== verilog/instr_aligner.sv ====
// Line and held half-word registers with the output instruction multiplexer
`default_nettype none

module instr_aligner
  import fetch_types_pkg::*;
  import fetch_ctrl_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire word_t      mem_rdata_i,   // Response data from instruction memory
  input  wire logic       line_load_i,   // Capture the response into the line
  input  wire logic       hold_upper_i,  // Move the old upper half to the hold register
  input  wire logic       invalidate_i,  // Drop line and held half
  input  wire instr_fmt_e fmt_i,
  output word_t           rdata_o,
  output logic            line_valid_o,
  output logic            hold_valid_o,
  output logic            low_is_c_o,
  output logic            high_is_c_o
);

  word_t line_q;  // Last fetched word
  half_t hold_q;  // Upper half of the previous word during a straddle

  //////////////////////////////
  // Payload registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (line_load_i) begin
      if (hold_upper_i) begin
        hold_q <= line_q[XLEN-1:HALF_W];  // Old contents before the new word lands
      end
      line_q <= mem_rdata_i;
    end
  end

  //////////////////////////////
  // Valid flags
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_valid_o <= 1'b0;
      hold_valid_o <= 1'b0;
    end else if (invalidate_i) begin
      line_valid_o <= 1'b0;
      hold_valid_o <= 1'b0;
    end else if (line_load_i) begin
      line_valid_o <= 1'b1;
      hold_valid_o <= hold_upper_i;
    end else if (hold_upper_i) begin
      hold_valid_o <= 1'b0;  // Straddle consumed and the line now belongs to the PC word
    end
  end

  assign low_is_c_o  = line_q[1:0] != FULL_OPCODE_BITS;
  assign high_is_c_o = line_q[HALF_W+1:HALF_W] != FULL_OPCODE_BITS;

  // Compressed parcels leave the upper half zero
  always_comb begin
    unique case (fmt_i)
      LINE_LOW_C:  rdata_o = {{HALF_W{1'b0}}, line_q[HALF_W-1:0]};
      LINE_FULL:   rdata_o = line_q;
      LINE_HIGH_C: rdata_o = {{HALF_W{1'b0}}, line_q[XLEN-1:HALF_W]};
      STRADDLE:    rdata_o = {line_q[HALF_W-1:0], hold_q};
      default:     rdata_o = line_q;
    endcase
  end

endmodule : instr_aligner

`default_nettype wire

// ==== verilog/fetch_ctrl.sv ====
// Fetch control FSM: memory access sequencing, branch aborts, format choice and decode hand-off
`default_nettype none

module fetch_ctrl
  import fetch_ctrl_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,

  // Decode side
  input  wire logic  req_i,            // Decode wants instructions
  input  wire logic  branch_i,         // One-cycle redirect pulse
  input  wire logic  ready_i,          // Decode accepts the presented instruction
  output logic       valid_o,          // An instruction is presented

  // Memory handshake
  output logic       instr_req_o,
  input  wire logic  instr_gnt_i,
  input  wire logic  instr_rvalid_i,
  output logic       busy_o,

  // Address unit
  input  wire logic  pc_bit1_i,        // PC points at the upper half of its word
  output logic       pc_load_o,
  output logic       pc_advance_o,
  output logic       step4_o,
  output logic       req_next_word_o,

  // Aligner
  input  wire logic  line_valid_i,
  input  wire logic  hold_valid_i,
  input  wire logic  low_is_c_i,
  input  wire logic  high_is_c_i,
  output logic       line_load_o,
  output logic       hold_upper_o,
  output logic       invalidate_o,
  output instr_fmt_e fmt_o
);

  mem_state_e state_q, state_d;

  logic instr_complete;  // Whole instruction at the PC already sits in the registers
  logic need_next;       // Full instruction in the upper half waits for the following word
  logic transfer;        // Handshake with decode completes this cycle

  //////////////////////////////
  // Format and completeness
  //////////////////////////////

  always_comb begin
    if (hold_valid_i) begin
      fmt_o = STRADDLE;  // Held half implies PC bit 1 set and the next word in the line
    end else if (!pc_bit1_i) begin
      fmt_o = low_is_c_i ? LINE_LOW_C : LINE_FULL;
    end else begin
      fmt_o = LINE_HIGH_C;  // Only presented when the upper parcel really is compressed
    end
  end

  assign instr_complete = hold_valid_i || (line_valid_i && (!pc_bit1_i || high_is_c_i));
  assign need_next      = line_valid_i && pc_bit1_i && !hold_valid_i && !high_is_c_i;

  // The fetch target follows from the registers alone, so it stays put for the whole access
  assign req_next_word_o = need_next;
  assign step4_o         = (fmt_o == LINE_FULL) || (fmt_o == STRADDLE);

  assign valid_o  = (state_q == IDLE) && !branch_i && instr_complete;  // Branch cycle shows nothing
  assign transfer = valid_o && ready_i;
  assign busy_o   = (state_q != IDLE) || instr_req_o;

  //////////////////////////////
  // Access sequencing
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    pc_load_o    = 1'b0;
    pc_advance_o = 1'b0;
    line_load_o  = 1'b0;
    hold_upper_o = 1'b0;
    invalidate_o = 1'b0;

    // A redirect in any state takes the target and drops everything buffered
    if (branch_i) begin
      pc_load_o    = 1'b1;
      invalidate_o = 1'b1;
    end

    unique case (state_q)
      IDLE: begin
        if (transfer) begin
          pc_advance_o = 1'b1;
          if (fmt_o == STRADDLE) begin
            hold_upper_o = 1'b1;  // Releases the held half and keeps the line for the new PC
          end else if (fmt_o != LINE_LOW_C) begin
            invalidate_o = 1'b1;  // PC leaves this word
          end
        end else if (req_i && !branch_i && !instr_complete) begin
          instr_req_o = 1'b1;  // Current word, or the next one for a straddle
          state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        instr_req_o = 1'b1;  // Held until granted
        if (instr_gnt_i) begin
          state_d = branch_i ? WAIT_ABORTED : WAIT_RVALID;
        end
        // Without a grant a branch just retargets the request to the new PC word
      end

      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          state_d = IDLE;
          if (!branch_i) begin
            line_load_o  = 1'b1;
            hold_upper_o = need_next;  // Keep the first half of a straddling instruction
          end
        end else if (branch_i) begin
          state_d = WAIT_ABORTED;  // Response still on its way and belongs to the old path
        end
      end

      WAIT_ABORTED: begin
        if (instr_rvalid_i) begin
          // Stale data is consumed here and never loaded
          if (req_i && !branch_i) begin
            instr_req_o = 1'b1;  // PC already holds the target and the line is empty
            state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end else begin
            state_d = IDLE;
          end
        end
      end

      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////
  // State register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule : fetch_ctrl

`default_nettype wire

// ==== verilog/prefetch_top.sv ====
// Fetch stage top level joining control, address unit and aligner to decode and memory
`default_nettype none

module prefetch_top
  import fetch_types_pkg::*;
  import fetch_ctrl_pkg::*;
#(
  parameter addr_t RESET_PC = '0
) (
  input  wire logic  clk,
  input  wire logic  rst_n,

  // Decode side
  input  wire logic  req_i,
  input  wire logic  branch_i,
  input  wire addr_t addr_i,
  input  wire logic  ready_i,
  output logic       valid_o,
  output word_t      rdata_o,
  output addr_t      addr_o,

  // Instruction memory
  output logic       instr_req_o,
  input  wire logic  instr_gnt_i,
  output addr_t      instr_addr_o,
  input  wire word_t instr_rdata_i,
  input  wire logic  instr_rvalid_i,

  output logic       busy_o
);

  logic       pc_load, pc_advance, step4, req_next_word;
  logic       line_load, hold_upper, invalidate;
  logic       line_valid, hold_valid, low_is_c, high_is_c;
  instr_fmt_e fmt;

  fetch_ctrl u_ctrl (
    .clk, .rst_n, .req_i, .branch_i, .ready_i, .valid_o,
    .instr_req_o, .instr_gnt_i, .instr_rvalid_i, .busy_o,
    .pc_bit1_i       (addr_o[1]),  // The reported address is the PC itself
    .pc_load_o       (pc_load),
    .pc_advance_o    (pc_advance),
    .step4_o         (step4),
    .req_next_word_o (req_next_word),
    .line_valid_i    (line_valid),
    .hold_valid_i    (hold_valid),
    .low_is_c_i      (low_is_c),
    .high_is_c_i     (high_is_c),
    .line_load_o     (line_load),
    .hold_upper_o    (hold_upper),
    .invalidate_o    (invalidate),
    .fmt_o           (fmt)
  );

  fetch_addr_unit #(.RESET_PC(RESET_PC)) u_addr (
    .clk, .rst_n,
    .pc_load_i       (pc_load),
    .branch_addr_i   (addr_i),
    .pc_advance_i    (pc_advance),
    .step4_i         (step4),
    .req_next_word_i (req_next_word),
    .pc_o            (addr_o),
    .mem_addr_o      (instr_addr_o)
  );

  instr_aligner u_align (
    .clk, .rst_n,
    .mem_rdata_i  (instr_rdata_i),
    .line_load_i  (line_load),
    .hold_upper_i (hold_upper),
    .invalidate_i (invalidate),
    .fmt_i        (fmt),
    .rdata_o      (rdata_o),
    .line_valid_o (line_valid),
    .hold_valid_o (hold_valid),
    .low_is_c_o   (low_is_c),
    .high_is_c_o  (high_is_c)
  );

endmodule : prefetch_top

`default_nettype wire

// ==== verif/imem_model.sv ====
// Instruction memory responder with random grant delay, random response latency and overlap flag
`default_nettype none

module imem_model
  import fetch_types_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  req_i,
  input  wire addr_t addr_i,
  output logic       gnt_o,
  output logic       rvalid_o,          // High for exactly one cycle per granted access
  output word_t      rdata_o,
  output addr_t      lookup_addr_o,     // Word whose contents the testbench supplies
  input  wire word_t lookup_data_i,
  output logic       overlap_o          // Sticky, set when a grant lands on an open access
);
  timeunit 1ns;
  timeprecision 1ps;

  logic       gnt_roll;   // Grant offered in this cycle
  logic       pending_q;  // Granted access still waiting for its response
  logic [1:0] delay_q;    // Cycles left before rvalid is raised
  addr_t      addr_q;

  assign gnt_o         = req_i && gnt_roll;
  assign lookup_addr_o = addr_q;

  //////////////////////////////
  // Handshake seen at the clock edge
  //////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
      delay_q   <= '0;
      addr_q    <= '0;
      overlap_o <= 1'b0;
    end else begin
      // A response in the same cycle closes the old access, so a new grant is legal then
      if (gnt_o && pending_q && !rvalid_o) overlap_o <= 1'b1;
      if (gnt_o) begin
        pending_q <= 1'b1;
        addr_q    <= addr_i;
        delay_q   <= 2'($urandom_range(0, 2));
      end else if (rvalid_o) begin
        pending_q <= 1'b0;
      end else if (pending_q && delay_q != 0) begin
        delay_q <= delay_q - 2'd1;  // Counting down the response latency
      end
    end
  end

  // Outputs change on the falling edge
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_roll <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      gnt_roll <= $urandom_range(0, 3) != 0;               // Roughly three grants in four
      rvalid_o <= pending_q && delay_q == 0 && !rvalid_o;  // One-cycle pulse
      rdata_o  <= lookup_data_i;
    end
  end

endmodule : imem_model

`default_nettype wire

// ==== verif/tb_prefetch.sv ====
// Fetch stage testbench with clock, reset, stimulus phases, reference PC model and checks
`default_nettype none

module tb_prefetch
  import fetch_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam addr_t       START_PC   = 32'h0000_1000;
  localparam int unsigned SEED       = 32'hd05a_0724;
  localparam int unsigned TIMEOUT    = 20000;  // Cycles allowed for any single wait
  localparam int unsigned SEQ_COUNT  = 400;    // Transfers in the sequential stream
  localparam int unsigned RAND_COUNT = 600;    // Transfers under random stalls and branches

  logic  clk = 1'b0;
  logic  rst_n, req, branch, ready, valid;
  logic  instr_req, instr_gnt, instr_rvalid, busy, overlap;
  addr_t branch_addr, addr, instr_addr, lookup_addr;
  word_t rdata, instr_rdata, lookup_data;

  addr_t       exp_pc     = START_PC;  // Reference program counter
  int unsigned xfer_count = 0;
  logic        stall_q    = 1'b0;      // Previous cycle presented an instruction that was refused
  logic        req_wait_q = 1'b0;      // Previous cycle had a request without a grant
  logic        branch_q   = 1'b0;
  word_t       stall_rdata_q;
  addr_t       stall_addr_q, req_addr_q;

  always #10 clk = ~clk;

  prefetch_top #(.RESET_PC(START_PC)) dut (
    .clk(clk), .rst_n(rst_n), .req_i(req), .branch_i(branch), .addr_i(branch_addr),
    .ready_i(ready), .valid_o(valid), .rdata_o(rdata), .addr_o(addr),
    .instr_req_o(instr_req), .instr_gnt_i(instr_gnt), .instr_addr_o(instr_addr),
    .instr_rdata_i(instr_rdata), .instr_rvalid_i(instr_rvalid), .busy_o(busy)
  );

  imem_model u_imem (
    .clk(clk), .rst_n(rst_n), .req_i(instr_req), .addr_i(instr_addr), .gnt_o(instr_gnt),
    .rvalid_o(instr_rvalid), .rdata_o(instr_rdata), .lookup_addr_o(lookup_addr),
    .lookup_data_i(lookup_data), .overlap_o(overlap)
  );

  //////////////////////////////
  // Program image and reference
  //////////////////////////////

  // The word address is hashed and each parcel then gets low bits that mix full and compressed
  function automatic word_t mem_word(input addr_t a);
    word_t x;
    half_t lo, hi;
    x  = (a >> 2) * 32'h9e37_79b9 + 32'h7f4a_7c15;
    x  = x ^ (x >> 15);
    x  = x * 32'h2c1b_3c6d;
    x  = x ^ (x >> 12);
    lo = x[15:0];
    hi = x[31:16];
    lo[1:0] = x[20] ? 2'b11 : {1'b0, x[7]};
    hi[1:0] = x[25] ? 2'b11 : {x[11], 1'b0};
    return {hi, lo};
  endfunction

  function automatic half_t parcel_at(input addr_t a);
    word_t w;
    w = mem_word(a);
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // Compressed parcels come zero-extended and full ones take the next parcel above
  function automatic word_t expected_instr(input addr_t pc);
    half_t lo;
    lo = parcel_at(pc);
    if (lo[1:0] != 2'b11) return {16'h0000, lo};
    return {parcel_at(pc + 32'd2), lo};
  endfunction

  function automatic addr_t step_of(input addr_t pc);
    half_t lo;
    lo = parcel_at(pc);
    return (lo[1:0] == 2'b11) ? 32'd4 : 32'd2;
  endfunction

  assign lookup_data = mem_word(lookup_addr);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input word_t got, input word_t want);
    abort_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, sig, got, want));
  endtask

  //////////////////////////////
  // Checks at every rising edge
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (stall_q && !branch) begin  // A branch may drop a stalled instruction
        assert (valid) else abort_run("valid_o dropped while decode was stalling");
        assert (rdata == stall_rdata_q) else report_mismatch("rdata_o", rdata, stall_rdata_q);
        assert (addr == stall_addr_q) else report_mismatch("addr_o", addr, stall_addr_q);
      end
      if (branch) begin
        assert (!valid) else abort_run("instruction presented in a branch cycle");
        exp_pc <= branch_addr;
      end else if (valid && ready) begin
        assert (addr == exp_pc) else report_mismatch("addr_o", addr, exp_pc);
        assert (rdata == expected_instr(exp_pc))
          else report_mismatch("rdata_o", rdata, expected_instr(exp_pc));
        exp_pc     <= exp_pc + step_of(exp_pc);
        xfer_count <= xfer_count + 1;
      end
      if (instr_req) begin
        assert (instr_addr[1:0] == 2'b00)
          else report_mismatch("instr_addr_o[1:0]", word_t'(instr_addr[1:0]), '0);
        assert (busy) else abort_run("busy_o low while instr_req_o is high");
      end
      // A branch retargets a request that is still waiting for its grant
      if (req_wait_q && !branch_q) begin
        assert (instr_req) else abort_run("instr_req_o dropped before its grant");
        assert (instr_addr == req_addr_q)
          else report_mismatch("instr_addr_o", instr_addr, req_addr_q);
      end
      assert (!overlap) else abort_run("second memory access granted while one was open");
    end
    stall_q       <= rst_n && valid && !ready;
    stall_rdata_q <= rdata;
    stall_addr_q  <= addr;
    req_wait_q    <= rst_n && instr_req && !instr_gnt;
    req_addr_q    <= instr_addr;
    branch_q      <= branch;
  end

  task automatic wait_transfers(input int unsigned n);
    int unsigned goal;
    int unsigned cycles;
    goal   = xfer_count + n;
    cycles = 0;
    while (xfer_count < goal && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (xfer_count < goal) abort_run("timeout while waiting for instruction transfers");
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int unsigned goal;
    int unsigned cycles;
    void'($urandom(SEED));
    rst_n       = 1'b0;
    req         = 1'b0;
    branch      = 1'b0;
    ready       = 1'b0;
    branch_addr = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle with no request from decode
    repeat (5) begin
      @(posedge clk);
      assert (!valid && !instr_req && !busy) else abort_run("fetch stage active without req_i");
    end

    @(negedge clk);
    req   = 1'b1;
    ready = 1'b1;
    wait_transfers(SEQ_COUNT);

    // Targets sit in the upper half of a word and about half of them straddle
    repeat (32) begin
      @(negedge clk);
      branch      = 1'b1;
      branch_addr = ($urandom & 32'h0000_fffc) | 32'h2;
      @(negedge clk);
      branch = 1'b0;
      wait_transfers(3);
    end

    goal   = xfer_count + RAND_COUNT;
    cycles = 0;
    while (xfer_count < goal && cycles < TIMEOUT) begin
      @(negedge clk);
      ready       = $urandom_range(0, 3) != 0;
      branch      = !branch && ($urandom_range(0, 15) == 0);  // Never two pulses in a row
      branch_addr = $urandom & 32'h0000_fffe;
      cycles++;
    end
    if (xfer_count < goal) abort_run("timeout in the random stall and branch phase");
    @(negedge clk);
    branch = 1'b0;
    ready  = 1'b1;
    wait_transfers(4);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : tb_prefetch

`default_nettype wire

// ==== compile.f ====
verilog/fetch_types_pkg.sv
verilog/fetch_ctrl_pkg.sv
verilog/fetch_addr_unit.sv
verilog/instr_aligner.sv
verilog/fetch_ctrl.sv
verilog/prefetch_top.sv
verif/imem_model.sv
verif/tb_prefetch.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_prefetch

.PHONY: all run clean

all: run

$(SIM): compile.f $(wildcard verilog/*.sv) $(wildcard verif/*.sv)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_prefetch \
		-f compile.f -o Vtb_prefetch

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
